// ==== hdl/wbx_crossbar.sv ====
// Crossbar core with per-target arbitration, request mux to the slaves, response return and error target
`timescale 1ns/1ns

module wbx_crossbar (
	input logic clk,
	input logic rstn,
	input wbx_pkg::wb_req_t m_req_i [wbx_pkg::N_MASTERS],
	output wbx_pkg::wb_rsp_t m_rsp_o [wbx_pkg::N_MASTERS],
	input wbx_pkg::tgt_id_t tgt_i [wbx_pkg::N_MASTERS],
	output wbx_pkg::wb_req_t s_req_o [wbx_pkg::N_SLAVES],
	input wbx_pkg::wb_rsp_t s_rsp_i [wbx_pkg::N_SLAVES]
);
	import wbx_pkg::*;

	// Per-target view with the slaves first and the error target last
	logic [N_MASTERS-1:0] t_req [N_TARGETS];
	logic t_gnt [N_TARGETS];
	mst_id_t t_gnt_id [N_TARGETS];
	wb_req_t t_bus [N_TARGETS];
	wb_rsp_t t_rsp [N_TARGETS];

	// Per-master response select
	logic hit [N_MASTERS];

	// Error responder flag
	logic err_q;

	for (genvar t = 0; t < N_TARGETS; t++) begin : g_tgt
		// Requesters are the masters whose tracker points here
		for (genvar m = 0; m < N_MASTERS; m++) begin : g_req
			assign t_req[t][m] = (tgt_i[m] == tgt_id_t'(t));
		end

		wbx_rr_arbiter u_arb (
			.clk(clk),
			.rstn(rstn),
			.req_i(t_req[t]),
			.gnt_o(t_gnt[t]),
			.gnt_id_o(t_gnt_id[t])
		);

		// Owner must still point here
		// Masks the release cycle right after ack
		assign t_bus[t] = (t_gnt[t] && t_req[t][t_gnt_id[t]]) ? m_req_i[t_gnt_id[t]] : '0;
	end

	// Slave ports
	for (genvar s = 0; s < N_SLAVES; s++) begin : g_slv
		assign s_req_o[s] = t_bus[s];
		assign t_rsp[s] = s_rsp_i[s];

		// A strobed port keeps its granted owner until the slave answers
		a_owner_held: assert property (@(posedge clk) disable iff (!rstn)
			(s_req_o[s].stb && !(s_rsp_i[s].ack || s_rsp_i[s].err)) |=>
			(s_req_o[s].stb && t_gnt[s] && $stable(t_gnt_id[s])));
	end

	// Decode-error target
	// err follows a granted strobe by one cycle and lasts a single cycle
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_q <= 1'b0;
		end else begin
			err_q <= t_bus[N_TARGETS-1].cyc && t_bus[N_TARGETS-1].stb && !err_q;
		end
	end

	// Never acks and reads as zero
	assign t_rsp[N_TARGETS-1] = '{dat_r: '0, ack: 1'b0, err: err_q};

	// Response return
	for (genvar m = 0; m < N_MASTERS; m++) begin : g_rsp
		// Only the granted owner of its chosen target sees the slave
		assign hit[m] = (tgt_i[m] < tgt_id_t'(N_TARGETS)) && t_gnt[tgt_i[m]] &&
			(t_gnt_id[tgt_i[m]] == mst_id_t'(m));
		assign m_rsp_o[m] = hit[m] ? t_rsp[tgt_i[m]] : '0;
	end

endmodule

// ==== hdl/wbx_interconnect.sv ====
// Top level of the 2x4 Wishbone interconnect: master trackers plus crossbar, address map set here
`timescale 1ns/1ns

module wbx_interconnect #(
	// Slave k at 0x1000*k, 4 KiB each
	// Highest slave first in the concatenation
	parameter wbx_pkg::addr_map_t map = {
		// Slave 3
		32'h0000_3000,
		32'h0000_3fff,
		// Slave 2
		32'h0000_2000,
		32'h0000_2fff,
		// Slave 1
		32'h0000_1000,
		32'h0000_1fff,
		// Slave 0
		32'h0000_0000,
		32'h0000_0fff
	}
) (
	input logic clk,
	input logic rstn,
	input wbx_pkg::wb_req_t m_req_i [wbx_pkg::N_MASTERS],
	output wbx_pkg::wb_rsp_t m_rsp_o [wbx_pkg::N_MASTERS],
	output wbx_pkg::wb_req_t s_req_o [wbx_pkg::N_SLAVES],
	input wbx_pkg::wb_rsp_t s_rsp_i [wbx_pkg::N_SLAVES]
);
	import wbx_pkg::*;

	// Target chosen by each master
	tgt_id_t tgt [N_MASTERS];

	// One tracker per master
	// Sees its own returned response to close the access
	for (genvar m = 0; m < N_MASTERS; m++) begin : g_trk
		wbx_master_tracker #(
			.map(map)
		) u_trk (
			.clk(clk),
			.rstn(rstn),
			.req_i(m_req_i[m]),
			.rsp_i(m_rsp_o[m]),
			.tgt_o(tgt[m])
		);
	end

	// Arbitration and routing
	wbx_crossbar u_xbar (
		.clk(clk),
		.rstn(rstn),
		.m_req_i(m_req_i),
		.m_rsp_o(m_rsp_o),
		.tgt_i(tgt),
		.s_req_o(s_req_o),
		.s_rsp_i(s_rsp_i)
	);

endmodule

// ==== hdl/wbx_master_tracker.sv ====
// Decodes one master's address when a cycle starts and holds the target until ack or err
`timescale 1ns/1ns

module wbx_master_tracker #(
	parameter wbx_pkg::addr_map_t map = '0
) (
	input logic clk,
	input logic rstn,
	input wbx_pkg::wb_req_t req_i,
	input wbx_pkg::wb_rsp_t rsp_i,
	output wbx_pkg::tgt_id_t tgt_o
);
	import wbx_pkg::*;

	trk_state_e state;
	tgt_id_t tgt_q;

	// Address decode against the map
	// Lowest slave index wins on overlapping windows
	function automatic tgt_id_t decode(input wb_addr_t adr);
		tgt_id_t sel;
		// Falls back to the error target when nothing matches
		sel = tgt_id_t'(N_TARGETS - 1);
		// Walk downward so the lowest match is left standing
		for (int k = N_SLAVES - 1; k >= 0; k--) begin
			if (adr >= map[k].base && adr <= map[k].limit) begin
				sel = tgt_id_t'(k);
			end
		end
		return sel;
	endfunction

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= TRK_IDLE;
			tgt_q <= TGT_NONE;
		end else begin
			case (state)
				TRK_IDLE: begin
					// Latch the target of a new strobe
					if (req_i.cyc && req_i.stb) begin
						state <= TRK_BUSY;
						tgt_q <= decode(req_i.adr);
					end
				end
				TRK_BUSY: begin
					// Response ends the access
					if (rsp_i.ack || rsp_i.err) begin
						state <= TRK_IDLE;
						tgt_q <= TGT_NONE;
					end
				end
				default: begin
					state <= TRK_IDLE;
					tgt_q <= TGT_NONE;
				end
			endcase
		end
	end

	// Registered so that adr has no same-cycle path to the arbiters
	assign tgt_o = tgt_q;

	// Held target must still match the address of the waiting master
	a_tgt_match: assert property (@(posedge clk) disable iff (!rstn)
		(state == TRK_BUSY) |-> (req_i.cyc && req_i.stb && tgt_o == decode(req_i.adr)));

endmodule

// ==== hdl/wbx_pkg.sv ====
// Shared widths, typedefs and bus structs for the 2x4 Wishbone crossbar, imported by every RTL file
package wbx_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Port counts
	localparam int N_MASTERS = 2;
	localparam int N_SLAVES = 4;
	// Last target index is the internal decode-error responder
	localparam int N_TARGETS = N_SLAVES + 1;

	typedef logic [ADDR_W-1:0] wb_addr_t;
	typedef logic [DATA_W-1:0] wb_data_t;
	typedef logic [DATA_W/8-1:0] wb_sel_t;
	typedef logic [$clog2(N_MASTERS)-1:0] mst_id_t;
	typedef logic [$clog2(N_TARGETS)-1:0] tgt_id_t;

	// Tracker output when no cycle is in flight
	localparam tgt_id_t TGT_NONE = '1;

	// Master to slave bundle, 71 bits
	typedef struct packed {
		wb_addr_t adr;
		wb_data_t dat_w;
		wb_sel_t sel;
		logic we;
		logic cyc;
		logic stb;
	} wb_req_t;

	// Slave to master bundle, 34 bits
	typedef struct packed {
		wb_data_t dat_r;
		logic ack;
		logic err;
	} wb_rsp_t;

	// Inclusive address window of one slave
	typedef struct packed {
		wb_addr_t base;
		wb_addr_t limit;
	} addr_range_t;

	typedef addr_range_t [N_SLAVES-1:0] addr_map_t;

	typedef enum logic {TRK_IDLE, TRK_BUSY} trk_state_e;
	typedef enum logic {ARB_IDLE, ARB_GRANTED} arb_state_e;

endpackage

// ==== hdl/wbx_rr_arbiter.sv ====
// Two-requester round-robin arbiter with last-grant masking that serves one crossbar target
`timescale 1ns/1ns

module wbx_rr_arbiter (
	input logic clk,
	input logic rstn,
	input logic [wbx_pkg::N_MASTERS-1:0] req_i,
	output logic gnt_o,
	output wbx_pkg::mst_id_t gnt_id_o
);
	import wbx_pkg::*;

	arb_state_e state;
	logic [N_MASTERS-1:0] gnt_q;
	logic [N_MASTERS-1:0] last_gnt_q;
	mst_id_t gnt_id_q;

	// Priority vectors
	logic [N_MASTERS-1:0] mask;
	logic [N_MASTERS-1:0] masked_gnt;
	logic [N_MASTERS-1:0] unmasked_gnt;
	logic [N_MASTERS-1:0] next_gnt;
	mst_id_t next_id;

	// Isolate the lowest set bit
	function automatic logic [N_MASTERS-1:0] pick_low(input logic [N_MASTERS-1:0] v);
		logic [N_MASTERS-1:0] one;
		logic found;
		one = '0;
		found = 1'b0;
		for (int i = 0; i < N_MASTERS; i++) begin
			if (v[i] && !found) begin
				one[i] = 1'b1;
				found = 1'b1;
			end
		end
		return one;
	endfunction

	always_comb begin
		// Mask keeps only requesters above the last winner
		mask[0] = 1'b0;
		for (int i = 1; i < N_MASTERS; i++) begin
			mask[i] = mask[i-1] | last_gnt_q[i-1];
		end
		masked_gnt = pick_low(req_i & mask);
		// Plain priority with the lowest index first
		unmasked_gnt = pick_low(req_i);
		next_gnt = (|masked_gnt) ? masked_gnt : unmasked_gnt;
		next_id = '0;
		for (int i = 0; i < N_MASTERS; i++) begin
			if (next_gnt[i]) begin
				next_id = mst_id_t'(i);
			end
		end
	end

	// last_gnt_q clears to zero so that master 0 leads after reset
	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= ARB_IDLE;
			gnt_q <= '0;
			last_gnt_q <= '0;
			gnt_id_q <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (|next_gnt) begin
						state <= ARB_GRANTED;
						gnt_q <= next_gnt;
						last_gnt_q <= next_gnt;
						gnt_id_q <= next_id;
					end
				end
				ARB_GRANTED: begin
					// Free the target once the owner drops its request
					if ((gnt_q & req_i) == '0) begin
						state <= ARB_IDLE;
						gnt_q <= '0;
					end
				end
				default: begin
					state <= ARB_IDLE;
					gnt_q <= '0;
				end
			endcase
		end
	end

	assign gnt_o = (state == ARB_GRANTED);
	assign gnt_id_o = gnt_id_q;

	// With both requesting, the previous winner has to yield
	a_rr_turn: assert property (@(posedge clk) disable iff (!rstn)
		(state == ARB_IDLE && (&req_i) && (|last_gnt_q)) |=> (gnt_q != $past(last_gnt_q)));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds and runs the crossbar testbench with Verilator; exit status follows the test result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f vlog.f -o tb_top_sim
./obj_dir/tb_top_sim > sim.log
cat sim.log

if grep -qx "Done: no errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// ==== tb/tb_clkgen.sv ====
// Testbench clock and reset source, 100 ns clock with active-low reset held for the first cycles
`timescale 1ns/1ns

module tb_clkgen #(
	parameter int half_period = 50,
	parameter int reset_cycles = 3
) (
	output logic clk_o,
	output logic rstn_o
);
	initial begin
		clk_o = 1'b0;
		forever begin
			#half_period clk_o = ~clk_o;
		end
	end

	// Released on a falling edge, clear of the sampling edge
	initial begin
		rstn_o = 1'b0;
		repeat (reset_cycles) @(posedge clk_o);
		@(negedge clk_o);
		rstn_o = 1'b1;
	end

endmodule

// ==== tb/tb_slave_mem.sv ====
// Wishbone slave memory model for the testbench, 1024 words, acks after a set number of wait states
`timescale 1ns/1ns

module tb_slave_mem #(
	parameter int wait_states = 0
) (
	input logic clk,
	input logic rstn,
	input wbx_pkg::wb_req_t req_i,
	output wbx_pkg::wb_rsp_t rsp_o
);
	import wbx_pkg::*;

	wb_data_t mem [1024];
	int stall;
	logic ack_q;
	wb_data_t dat_q;
	logic [9:0] idx;

	// Word index inside the 4 KiB window
	assign idx = req_i.adr[11:2];

	always @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
			stall <= 0;
			dat_q <= '0;
		end else if (ack_q) begin
			// Ack lasts one cycle, then wait for the next strobe
			ack_q <= 1'b0;
			stall <= 0;
		end else if (req_i.cyc && req_i.stb) begin
			if (stall == wait_states) begin
				ack_q <= 1'b1;
				if (req_i.we) begin
					// Byte lanes follow sel
					for (int b = 0; b < DATA_W / 8; b++) begin
						if (req_i.sel[b]) begin
							mem[idx][8*b +: 8] <= req_i.dat_w[8*b +: 8];
						end
					end
				end else begin
					dat_q <= mem[idx];
				end
			end else begin
				stall <= stall + 1;
			end
		end else begin
			stall <= 0;
		end
	end

	assign rsp_o = '{dat_r: dat_q, ack: ack_q, err: 1'b0};

endmodule

// ==== tb/tb_top.sv ====
// Directed testbench for the 2x4 Wishbone crossbar, checks decode, arbitration, errors and stalls
`timescale 1ns/1ns

module tb_top;
	import wbx_pkg::*;

	// Six tests, about 30 accesses of at most 12 cycles, with wide margin
	localparam int max_cycles = 2000;

	logic clk;
	logic rstn;
	wb_req_t m_req [N_MASTERS];
	wb_rsp_t m_rsp [N_MASTERS];
	wb_req_t s_req [N_SLAVES];
	wb_rsp_t s_rsp [N_SLAVES];

	int errors;
	int tests_run;
	int tests_failed;
	int cycles;
	// Bus monitor counters
	int stb_cnt [N_SLAVES];
	int ack_cnt [N_MASTERS];
	int hold_viol;
	wb_req_t s_prev [N_SLAVES];
	logic s_wait [N_SLAVES];

	tb_clkgen i_clkgen (.clk_o(clk), .rstn_o(rstn));

	// Slaves 0 and 1 answer at once, 2 and 3 stall for 2 and 3 cycles
	for (genvar s = 0; s < N_SLAVES; s++) begin : g_mem
		tb_slave_mem #(.wait_states((s < 2) ? 0 : s)) i_mem (
			.clk(clk),
			.rstn(rstn),
			.req_i(s_req[s]),
			.rsp_o(s_rsp[s])
		);
	end

	wbx_interconnect i_dut (
		.clk(clk),
		.rstn(rstn),
		.m_req_i(m_req),
		.m_rsp_o(m_rsp),
		.s_req_o(s_req),
		.s_rsp_i(s_rsp)
	);

	// Monitor and watchdog, sampled at the rising edge
	always @(posedge clk) begin
		for (int s = 0; s < N_SLAVES; s++) begin
			if (s_req[s].cyc && s_req[s].stb) begin
				stb_cnt[s]++;
				// A stalled request must reach the next edge unchanged
				if (s_wait[s] && s_req[s] != s_prev[s]) begin
					hold_viol++;
				end
			end
			s_wait[s] = s_req[s].cyc && s_req[s].stb && !s_rsp[s].ack;
			s_prev[s] = s_req[s];
		end
		for (int m = 0; m < N_MASTERS; m++) begin
			if (m_rsp[m].ack) begin
				ack_cnt[m]++;
			end
		end
		cycles++;
		if (cycles >= max_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", max_cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	// One classic access by master m; returns the response and the cycle it came in
	task automatic bus_access(input int m, input logic we, input wb_addr_t adr,
			input wb_data_t dat, output wb_rsp_t rsp, output int done);
		@(negedge clk);
		m_req[m] = '{adr: adr, dat_w: dat, sel: '1, we: we, cyc: 1'b1, stb: 1'b1};
		// Response is settled by mid-cycle
		do begin
			@(negedge clk);
		end while (!(m_rsp[m].ack || m_rsp[m].err));
		rsp = m_rsp[m];
		done = cycles;
		// Hold across the edge that takes the response, then release
		@(negedge clk);
		m_req[m] = '0;
	endtask

	task automatic compare_word(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		assert (got === exp) else begin
			$display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic confirm(input logic ok, input string what);
		assert (ok) else begin
			$display("Error at t=%0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: %0d checks failed", name, errors - err_before);
		end
	endtask

	task automatic reset_values();
		int e0;
		e0 = errors;
		@(negedge clk);
		for (int s = 0; s < N_SLAVES; s++) begin
			compare_word($sformatf("s_req[%0d].cyc", s), 0, s_req[s].cyc);
			compare_word($sformatf("s_req[%0d].stb", s), 0, s_req[s].stb);
		end
		for (int m = 0; m < N_MASTERS; m++) begin
			compare_word($sformatf("m_rsp[%0d].ack", m), 0, m_rsp[m].ack);
			compare_word($sformatf("m_rsp[%0d].err", m), 0, m_rsp[m].err);
		end
		finish_test("reset", e0);
	endtask

	// Both masters on slave 1; runs first so the arbiter is still fresh
	task automatic contention();
		int e0;
		wb_data_t d [N_MASTERS];
		wb_rsp_t r [N_MASTERS];
		int done [N_MASTERS];
		e0 = errors;
		d[0] = $urandom;
		d[1] = $urandom;
		fork
			bus_access(0, 1'b1, 32'h1010, d[0], r[0], done[0]);
			bus_access(1, 1'b1, 32'h1020, d[1], r[1], done[1]);
		join
		confirm(done[0] < done[1], "master 1 was served before master 0 after reset");
		// Solo access leaves master 0 as the last winner
		bus_access(0, 1'b0, 32'h1010, '0, r[0], done[0]);
		compare_word("m_rsp[0].dat_r", d[0], r[0].dat_r);
		// Each reads the word the other wrote
		fork
			bus_access(0, 1'b0, 32'h1020, '0, r[0], done[0]);
			bus_access(1, 1'b0, 32'h1010, '0, r[1], done[1]);
		join
		confirm(done[1] < done[0], "master 0 won the tie although it was granted last");
		compare_word("m_rsp[0].dat_r", d[1], r[0].dat_r);
		compare_word("m_rsp[1].dat_r", d[0], r[1].dat_r);
		finish_test("contention", e0);
	endtask

	task automatic address_decode();
		int e0;
		int seen [N_SLAVES];
		wb_addr_t adr;
		wb_data_t d;
		wb_rsp_t r;
		int t;
		e0 = errors;
		for (int k = 0; k < N_SLAVES; k++) begin
			seen = stb_cnt;
			// Random word inside slave k's 4 KiB window
			adr = 32'h1000 * k + ($urandom & 32'hffc);
			d = $urandom;
			bus_access(0, 1'b1, adr, d, r, t);
			bus_access(0, 1'b0, adr, '0, r, t);
			compare_word($sformatf("m_rsp[0].dat_r at %h", adr), d, r.dat_r);
			for (int s = 0; s < N_SLAVES; s++) begin
				confirm((stb_cnt[s] != seen[s]) == (s == k),
					$sformatf("slave %0d strobe does not fit the decode of %h", s, adr));
			end
		end
		finish_test("decode", e0);
	endtask

	task automatic unmapped_access();
		int e0;
		int seen [N_SLAVES];
		int acks;
		wb_rsp_t r;
		int t;
		e0 = errors;
		seen = stb_cnt;
		acks = ack_cnt[0];
		bus_access(0, 1'b0, 32'h8000, '0, r, t);
		compare_word("m_rsp[0].err", 1, r.err);
		compare_word("m_rsp[0].ack", 0, r.ack);
		compare_word("m_rsp[0].dat_r", 0, r.dat_r);
		confirm(ack_cnt[0] == acks, "master 0 saw an ack for an unmapped address");
		for (int s = 0; s < N_SLAVES; s++) begin
			confirm(stb_cnt[s] == seen[s],
				$sformatf("slave %0d saw a strobe for an unmapped address", s));
		end
		finish_test("unmapped", e0);
	endtask

	// Slave 0 and slave 3 at once, no shared target
	task automatic parallel_access();
		int e0;
		wb_data_t d [N_MASTERS];
		wb_rsp_t r [N_MASTERS];
		int done [N_MASTERS];
		e0 = errors;
		d[0] = $urandom;
		d[1] = $urandom;
		fork
			bus_access(0, 1'b1, 32'h0040, d[0], r[0], done[0]);
			bus_access(1, 1'b1, 32'h3040, d[1], r[1], done[1]);
		join
		fork
			bus_access(0, 1'b0, 32'h0040, '0, r[0], done[0]);
			bus_access(1, 1'b0, 32'h3040, '0, r[1], done[1]);
		join
		compare_word("m_rsp[0].dat_r", d[0], r[0].dat_r);
		compare_word("m_rsp[1].dat_r", d[1], r[1].dat_r);
		finish_test("parallel", e0);
	endtask

	task automatic back_pressure();
		int e0;
		int viol;
		int acks;
		wb_addr_t adr;
		wb_data_t d;
		wb_rsp_t r;
		int t;
		e0 = errors;
		viol = hold_viol;
		acks = ack_cnt[0];
		// Slaves 2 and 3 stall every access
		for (int k = 2; k < N_SLAVES; k++) begin
			adr = 32'h1000 * k + 32'h80;
			d = $urandom;
			bus_access(0, 1'b1, adr, d, r, t);
			bus_access(0, 1'b0, adr, '0, r, t);
			compare_word($sformatf("m_rsp[0].dat_r at %h", adr), d, r.dat_r);
		end
		confirm(hold_viol == viol, "a request field changed while a slave was stalling");
		compare_word("m_rsp[0].ack count", 4, ack_cnt[0] - acks);
		finish_test("back-pressure", e0);
	endtask

	initial begin
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		cycles = 0;
		hold_viol = 0;
		for (int m = 0; m < N_MASTERS; m++) begin
			m_req[m] = '0;
			ack_cnt[m] = 0;
		end
		for (int s = 0; s < N_SLAVES; s++) begin
			stb_cnt[s] = 0;
			s_wait[s] = 1'b0;
			s_prev[s] = '0;
		end
		void'($urandom(32'h5ea2));
		wait (rstn === 1'b1);
		reset_values();
		contention();
		address_decode();
		unmapped_access();
		parallel_access();
		back_pressure();
		$display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
			tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
hdl/wbx_pkg.sv
hdl/wbx_master_tracker.sv
hdl/wbx_rr_arbiter.sv
hdl/wbx_crossbar.sv
hdl/wbx_interconnect.sv
tb/tb_clkgen.sv
tb/tb_slave_mem.sv
tb/tb_top.sv
